// ==== run_sim.sh ====
#!/bin/sh
# build and run the clock generator testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f verilog.f --top-module clkgen_tb -o clkgen_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "verilator build failed"
   exit 1
fi

./obj_dir/clkgen_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "Test OK" sim.log; then
   echo "result: pass"
   exit 0
fi
echo "result: fail"
exit 1

// ==== test/clkgen_tb.sv ====
// clock generator testbench
// random apb traffic against a per-channel model of both output clocks
`timescale 1ns/10ps
`default_nettype none

module clkgen_tb;

   localparam int num_ch       = 2;
   localparam int num_reconfig = 40;
   localparam int max_cycles   = num_reconfig * 1200 + 12000; // ~1200 per reconfig, rest margin

   logic              clk;
   logic              nreset;
   logic [7:0]        paddr;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [31:0]       pwdata;
   logic [31:0]       prdata;
   logic              pready;
   logic              pslverr;
   logic [num_ch-1:0] clkout;
   logic [num_ch-1:0] clkout90;

   int         cycles = 0;
   int         errors;
   int         checks;
   logic [3:0] model_code [num_ch]; // last accepted code
   logic       model_en   [num_ch];

   tb_clock #(.period_ns(40), .reset_cycles(16)) u_clock (.clk, .nreset);

   clkgen_top #(.NUM_CH(num_ch)) uut (
      .clk, .nreset,
      .paddr, .psel, .penable, .pwrite, .pwdata,
      .prdata, .pready, .pslverr,
      .clkout, .clkout90
   );

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= max_cycles) begin
         $display("timeout, run stopped after %0d clock cycles", cycles);
         $display("Test FAILED");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   function automatic string sig(input string base, input int ch);
      return $sformatf("%s[%0d]", base, ch);
   endfunction

   function automatic logic [7:0] ctrl_addr(input int ch);
      return clkgen_reg_pkg::ctrl_base + 8'(4 * ch);
   endfunction

   // ##########################################################
   // apb transfers, inputs change on falling edges
   // ##########################################################
   task automatic transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      @(negedge clk);               // setup
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk);               // access, response already registered
      penable = 1'b1;
      rdata   = prdata;
      err     = pslverr;
      check_value("pready", 32'(pready), 32'd1);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, output logic err);
      logic [31:0] unused_rdata;
      transfer(1'b1, addr, data, unused_rdata, err);
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
      transfer(1'b0, addr, 32'd0, data, err);
   endtask

   // legal write, model follows the register
   task automatic configure(input int ch, input logic [3:0] code, input logic en);
      logic err;
      write_reg(ctrl_addr(ch), {27'd0, en, code}, err);
      check_value("pslverr", 32'(err), 32'd0);
      model_code[ch] = code;
      model_en[ch]   = en;
   endtask

   task automatic verify_regs();
      logic [31:0] data;
      logic        err;
      for (int ch = 0; ch < num_ch; ch++) begin
         read_reg(ctrl_addr(ch), data, err);
         check_value("pslverr", 32'(err), 32'd0);
         check_value(sig("prdata ctrl", ch), data, {27'd0, model_en[ch], model_code[ch]});
      end
   endtask

   // poll status, the global cycle limit bounds this
   task automatic wait_idle(input int ch);
      logic [31:0] data;
      logic        err;
      data = 32'hffff_ffff;
      while (data[ch]) read_reg(clkgen_reg_pkg::status_addr, data, err);
   endtask

   // ##########################################################
   // output checks per divide code
   // ##########################################################
   task automatic check_passthrough(input int ch); // code 0, both outputs are clk
      for (int i = 0; i < 4; i++) begin
         @(posedge clk);
         #10;
         check_value(sig("clkout", ch), 32'(clkout[ch]), 32'd1);
         check_value(sig("clkout90", ch), 32'(clkout90[ch]), 32'd1);
         @(negedge clk);
         #10;
         check_value(sig("clkout", ch), 32'(clkout[ch]), 32'd0);
         check_value(sig("clkout90", ch), 32'(clkout90[ch]), 32'd0);
      end
   endtask

   // code 1, clkout90 is clkout half a cycle late
   task automatic check_half_shift(input int ch);
      logic prev_out;
      @(negedge clk);
      #10;
      prev_out = clkout[ch];
      for (int i = 0; i < 8; i++) begin
         @(posedge clk);
         #10;
         check_value(sig("clkout90", ch), 32'(clkout90[ch]), 32'(prev_out));
         if (model_en[ch]) check_value(sig("clkout", ch), 32'(clkout[ch]), 32'(!prev_out));
         prev_out = clkout[ch];
         @(negedge clk);
         #10;
         check_value(sig("clkout90", ch), 32'(clkout90[ch]), 32'(prev_out));
         prev_out = clkout[ch];
      end
   endtask

   task automatic check_frozen(input int ch, input int num_cycles);
      logic lvl;
      logic lvl90;
      @(negedge clk);
      lvl   = clkout[ch];
      lvl90 = clkout90[ch];
      repeat (num_cycles) begin
         @(negedge clk);
         check_value(sig("clkout", ch), 32'(clkout[ch]), 32'(lvl));
         check_value(sig("clkout90", ch), 32'(clkout90[ch]), 32'(lvl90));
      end
   endtask

   // codes 2..7 enabled, high N/2, low N/2, clkout90 N/4 behind
   task automatic measure_period(input int ch, input int n);
      int   hi;
      int   lo;
      int   d90;
      int   guard;
      logic prev;
      hi    = 0;
      lo    = 0;
      d90   = 0;
      guard = 0;
      @(negedge clk);
      prev = clkout[ch];
      @(negedge clk);
      while ((prev || !clkout[ch]) && guard < 4 * n) begin // look for a fresh rise
         prev = clkout[ch];
         guard++;
         @(negedge clk);
      end
      if (guard >= 4 * n) begin
         errors++;
         $display("no rising edge on clkout[%0d] within %0d cycles", ch, 4 * n);
      end else begin
         check_value(sig("clkout90", ch), 32'(clkout90[ch]), 32'd0);
         while (clkout[ch] && hi <= n) begin
            if (clkout90[ch] && d90 == 0) d90 = hi;
            hi++;
            @(negedge clk);
         end
         while (!clkout[ch] && lo <= n) begin
            lo++;
            @(negedge clk);
         end
         check_value(sig("clkout high cycles", ch), hi, n / 2);
         check_value(sig("clkout low cycles", ch), lo, n / 2);
         check_value(sig("clkout90 delay", ch), d90, n / 4);
      end
   endtask

   task automatic check_channel(input int ch);
      if (model_code[ch] == 4'd0) check_passthrough(ch);
      else if (model_code[ch] == 4'd1) check_half_shift(ch);
      else if (model_en[ch]) measure_period(ch, 1 << model_code[ch]);
      else check_frozen(ch, 16);
   endtask

   // ##########################################################
   // register access and error responses
   // ##########################################################
   task automatic register_tests();
      logic [31:0] data;
      logic        err;
      logic [7:0]  addr;
      int          ch;
      for (int i = 0; i < 24; i++) begin
         ch = int'($urandom_range(num_ch - 1));
         case ($urandom_range(3))
            0: begin
               configure(ch, 4'($urandom_range(7)), 1'($urandom_range(1)));
               wait_idle(ch);
            end
            1: begin // reserved code
               write_reg(ctrl_addr(ch), {27'd0, 1'b1, 4'($urandom_range(15, 8))}, err);
               check_value("pslverr", 32'(err), 32'd1);
            end
            2: begin // status is read only
               write_reg(clkgen_reg_pkg::status_addr, $urandom, err);
               check_value("pslverr", 32'(err), 32'd1);
            end
            default: begin
               addr = 8'($urandom);
               while (addr == ctrl_addr(0) || addr == ctrl_addr(1)
                      || addr == clkgen_reg_pkg::status_addr) addr = 8'($urandom);
               write_reg(addr, $urandom, err);
               check_value("pslverr", 32'(err), 32'd1);
               read_reg(addr, data, err);
               check_value("pslverr", 32'(err), 32'd1);
               check_value("prdata", data, 32'd0);
            end
         endcase
         verify_regs();
      end
   endtask

   // en low holds both outputs, a code change then loads at once
   task automatic freeze_test(input int ch);
      logic [31:0] data;
      logic        err;
      logic [3:0]  code;
      configure(ch, 4'($urandom_range(7, 2)), 1'b1);
      wait_idle(ch);
      configure(ch, model_code[ch], 1'b0);
      check_frozen(ch, int'($urandom_range(200, 20)));
      code = 4'($urandom_range(7));
      while (code == model_code[ch]) code = 4'($urandom_range(7));
      configure(ch, code, 1'b0);
      repeat (2) @(negedge clk);
      read_reg(clkgen_reg_pkg::status_addr, data, err); // sampled 3 cycles after cfg_write
      check_value(sig("status busy", ch), 32'(data[ch]), 32'd0);
   endtask

   initial begin : main
      logic [31:0] data;
      logic        err;
      int          ch;
      void'($urandom(33));
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      errors  = 0;
      checks  = 0;
      for (int c = 0; c < num_ch; c++) begin
         model_code[c] = 4'd0;
         model_en[c]   = 1'b0;
      end
      @(posedge nreset);

      // reset values, outputs follow clk with code 0
      verify_regs();
      read_reg(clkgen_reg_pkg::status_addr, data, err);
      check_value("prdata status", data, 32'd0);
      for (int c = 0; c < num_ch; c++) check_passthrough(c);

      register_tests();
      freeze_test(int'($urandom_range(num_ch - 1)));

      // random reconfig, every channel checked against its own model
      for (int i = 0; i < num_reconfig; i++) begin
         ch = int'($urandom_range(num_ch - 1));
         configure(ch, 4'($urandom_range(7)), $urandom_range(3) != 0);
         wait_idle(ch);
         verify_regs();
         for (int c = 0; c < num_ch; c++) check_channel(c);
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
// testbench clock and reset
// free running clk, nreset held low for the first cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
   parameter int period_ns    = 40,
   parameter int reset_cycles = 16
) (
   output logic clk,
   output logic nreset
);

   initial begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;
   end

   // released on a falling edge, away from the active edge
   initial begin
      nreset = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/clkgen_reg_pkg.sv
verilog/clkdiv_pkg.sv
verilog/clkgen_regs.sv
verilog/clkdiv_switch_fsm.sv
verilog/clkdiv_counter.sv
verilog/clkdiv_phase.sv
verilog/clkgen_top.sv
test/tb_clock.sv
test/clkgen_tb.sv

// ==== verilog/clkdiv_counter.sv ====
// edge counter for one divider channel
// decodes the active ratio and flags the four edge positions
`timescale 1ns/10ps
`default_nettype none

module clkdiv_counter (
   input  logic                                  clk,
   input  logic                                  nreset,
   input  logic [clkdiv_pkg::div_code_width-1:0] active_code,
   input  logic                                  en,
   input  logic                                  restart,
   output logic                                  rise_match,
   output logic                                  fall_match,
   output logic                                  rise90_match,
   output logic                                  fall90_match,
   output logic                                  period_end
);

   localparam int cw = clkdiv_pkg::cnt_width;

   logic [cw-1:0] ratio; // one-hot N, zero for divide by 1
   logic [cw-1:0] cnt;

   // ##########################################################
   // ratio decode
   // ##########################################################
   always_comb begin
      ratio = '0;
      if (active_code != '0 && active_code <= clkdiv_pkg::div_code_max) begin
         ratio = cw'(1) << active_code;
      end
   end

   // counts 1..N, frozen with en low
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cnt <= cw'(1);
      end else if (restart || rise_match) begin
         cnt <= cw'(1);         // self reload at end of period
      end else if (en) begin
         cnt <= cnt + cw'(1);
      end
   end

   // match points, gated so a disabled channel holds its level
   assign rise_match   = en && (cnt == ratio);                        // N
   assign fall_match   = en && (cnt == (ratio >> 1));                 // N/2
   assign rise90_match = en && (cnt == (ratio >> 2));                 // N/4
   assign fall90_match = en && (cnt == ((ratio >> 2) + (ratio >> 1))); // 3N/4

   assign period_end = rise_match;

   // restart from the fsm must land together with every code change
   a_cnt_in_range: assert property (@(posedge clk) disable iff (!nreset)
      (active_code != '0) |-> (cnt <= ratio));

endmodule

`default_nettype wire

// ==== verilog/clkdiv_phase.sv ====
// output stage for one divider channel
// 0 and 90 degree clocks, with divide-by-1 and divide-by-2 paths
`timescale 1ns/10ps
`default_nettype none

module clkdiv_phase (
   input  logic                                  clk,
   input  logic                                  nreset,
   input  logic [clkdiv_pkg::div_code_width-1:0] active_code,
   input  logic                                  rise_match,
   input  logic                                  fall_match,
   input  logic                                  rise90_match,
   input  logic                                  fall90_match,
   output logic                                  clkout,
   output logic                                  clkout90
);

   logic clkout_reg;
   logic clkout90_reg;
   logic clkout90_div2; // clkout_reg half a cycle late
   logic div1;
   logic div2;

   assign div1 = (active_code == 4'd0);
   assign div2 = (active_code == 4'd1);

   // ##########################################################
   // divided outputs
   // ##########################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         clkout_reg <= 1'b0;
      end else if (rise_match) begin
         clkout_reg <= 1'b1;
      end else if (fall_match) begin
         clkout_reg <= 1'b0;
      end
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         clkout90_reg <= 1'b0;
      end else if (rise90_match) begin
         clkout90_reg <= 1'b1;
      end else if (fall90_match) begin
         clkout90_reg <= 1'b0;
      end
   end

   // div2 has no N/4 point, so shift by a falling edge instead
   always_ff @(negedge clk or negedge nreset) begin
      if (!nreset) begin
         clkout90_div2 <= 1'b0;
      end else begin
         clkout90_div2 <= clkout_reg;
      end
   end

   // ##########################################################
   // output select
   // ##########################################################
   assign clkout   = div1 ? clk : clkout_reg;  // div1 passes clk through
   assign clkout90 = div1 ? clk
                   : div2 ? clkout90_div2
                   : clkout90_reg;

endmodule

`default_nettype wire

// ==== verilog/clkdiv_pkg.sv ====
// divider channel definitions
// divide code encoding, counter width, ratio switch states
`default_nettype none

package clkdiv_pkg;

   // divide code, ratio = 2**code
   localparam int div_code_width = 4;

   // 0..7 legal, 8..15 reserved
   localparam logic [div_code_width-1:0] div_code_max = 4'd7;

   // edge counter, wide enough for ratio 128
   localparam int cnt_width = 8;

   // ##########################################################
   // ratio switch fsm
   // ##########################################################
   typedef enum logic [1:0] {
      sw_idle, // active code in use
      sw_wait, // pending code held, waiting for end of period
      sw_load  // one cycle, copy pending code and restart counter
   } switch_state_t;

endpackage

`default_nettype wire

// ==== verilog/clkdiv_switch_fsm.sv ====
// ratio switch fsm for one divider channel
// holds a new divide code until the current period closes
`timescale 1ns/10ps
`default_nettype none

module clkdiv_switch_fsm (
   input  logic                                  clk,
   input  logic                                  nreset,
   input  logic [clkdiv_pkg::div_code_width-1:0] cfg_code,
   input  logic                                  cfg_write,
   input  logic                                  en,
   input  logic                                  period_end,
   output logic [clkdiv_pkg::div_code_width-1:0] active_code,
   output logic                                  restart,
   output logic                                  busy
);

   clkdiv_pkg::switch_state_t state;
   clkdiv_pkg::switch_state_t state_nxt;

   logic [clkdiv_pkg::div_code_width-1:0] pending_code;
   logic                                  go;

   // no period to wait for with the output frozen or clk passed through
   assign go = period_end || !en || (active_code == '0);

   // ##########################################################
   // next state
   // ##########################################################
   always_comb begin
      state_nxt = state;
      case (state)
         clkdiv_pkg::sw_idle: begin
            if (cfg_write) state_nxt = clkdiv_pkg::sw_wait;
         end
         clkdiv_pkg::sw_wait: begin
            if (go) state_nxt = clkdiv_pkg::sw_load; // new writes just replace pending
         end
         clkdiv_pkg::sw_load: begin
            state_nxt = cfg_write ? clkdiv_pkg::sw_wait : clkdiv_pkg::sw_idle;
         end
         default: state_nxt = clkdiv_pkg::sw_idle;
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state       <= clkdiv_pkg::sw_idle;
         active_code <= '0;              // divide by 1 after reset
      end else begin
         state <= state_nxt;
         if (state == clkdiv_pkg::sw_load) begin
            active_code <= pending_code; // takes effect with restart
         end
      end
   end

   // latest requested code
   always_ff @(posedge clk) begin
      if (cfg_write) pending_code <= cfg_code;
   end

   assign restart = (state == clkdiv_pkg::sw_load);
   assign busy    = (state != clkdiv_pkg::sw_idle);

   // reserved codes are refused upstream and never reach the counter
   a_code_legal: assert property (@(posedge clk) disable iff (!nreset)
      (state == clkdiv_pkg::sw_load) |-> (pending_code <= clkdiv_pkg::div_code_max));

endmodule

`default_nettype wire

// ==== verilog/clkgen_reg_pkg.sv ====
// clock generator register map
// apb widths, register addresses and control field positions
`default_nettype none

package clkgen_reg_pkg;

   // bus widths
   localparam int apb_addr_width = 8;
   localparam int apb_data_width = 32;

   // ##########################################################
   // addresses
   // ##########################################################
   localparam logic [apb_addr_width-1:0] ctrl_base   = 8'h00; // channel n at base + 4n
   localparam logic [apb_addr_width-1:0] status_addr = 8'h20; // read only, busy per channel

   // control register fields
   localparam int ctrl_code_lsb   = 0;
   localparam int ctrl_code_width = 4;  // divide code
   localparam int ctrl_en_bit     = 4;  // channel enable

endpackage

`default_nettype wire

// ==== verilog/clkgen_regs.sv ====
// apb register file for the clock generator
// per-channel control registers, busy status, change pulses
`timescale 1ns/10ps
`default_nettype none

module clkgen_regs #(
   parameter int NUM_CH = 2
) (
   input  logic                                       clk,
   input  logic                                       nreset,
   input  logic [clkgen_reg_pkg::apb_addr_width-1:0]  paddr,
   input  logic                                       psel,
   input  logic                                       penable,
   input  logic                                       pwrite,
   input  logic [clkgen_reg_pkg::apb_data_width-1:0]  pwdata,
   output logic [clkgen_reg_pkg::apb_data_width-1:0]  prdata,
   output logic                                       pready,
   output logic                                       pslverr,
   output logic [clkdiv_pkg::div_code_width-1:0]      cfg_code [NUM_CH],
   output logic [NUM_CH-1:0]                          en,
   output logic [NUM_CH-1:0]                          cfg_write,
   input  logic [NUM_CH-1:0]                          busy
);

   localparam int addr_w = clkgen_reg_pkg::apb_addr_width;
   localparam int code_w = clkdiv_pkg::div_code_width;
   localparam logic [addr_w-1:0] ctrl_span = addr_w'(4 * NUM_CH); // bytes of ctrl space

   logic [addr_w-1:0] offset;   // address relative to ctrl_base
   logic [addr_w-3:0] ch_idx;   // word index = channel
   logic              is_ctrl;
   logic              is_status;
   logic              bad_code;
   logic              err;
   logic              setup;
   logic              access;
   logic              wr_ok;
   logic [code_w-1:0] wr_code;
   logic [clkgen_reg_pkg::apb_data_width-1:0] rdata;

   // ##########################################################
   // address decode and error check
   // ##########################################################
   assign offset    = paddr - clkgen_reg_pkg::ctrl_base;
   assign ch_idx    = offset[addr_w-1:2];
   assign is_ctrl   = (offset < ctrl_span) && (offset[1:0] == 2'b00);
   assign is_status = (paddr == clkgen_reg_pkg::status_addr);
   assign wr_code   = pwdata[clkgen_reg_pkg::ctrl_code_lsb +: clkgen_reg_pkg::ctrl_code_width];
   assign bad_code  = pwrite && is_ctrl && (wr_code > clkdiv_pkg::div_code_max);
   assign err       = !(is_ctrl || is_status)   // unmapped
                    || (pwrite && is_status)    // status is read only
                    || bad_code;                // reserved code refused

   assign setup  = psel && !penable;
   assign access = psel && penable;
   assign wr_ok  = access && pwrite && is_ctrl && !err;
   assign pready = 1'b1; // never stalls

   // read mux
   always_comb begin
      rdata = '0;
      if (is_status) begin
         rdata[NUM_CH-1:0] = busy;
      end else begin
         for (int i = 0; i < NUM_CH; i++) begin
            if (int'(ch_idx) == i) begin
               rdata[clkgen_reg_pkg::ctrl_code_lsb +: clkgen_reg_pkg::ctrl_code_width] = cfg_code[i];
               rdata[clkgen_reg_pkg::ctrl_en_bit] = en[i];
            end
         end
      end
   end

   // response registered in setup, valid through the access cycle
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         prdata  <= '0;
         pslverr <= 1'b0;
      end else begin
         pslverr <= setup && err;
         if (setup) begin
            prdata <= (!pwrite && !err) ? rdata : '0;
         end
      end
   end

   // ##########################################################
   // per-channel control fields
   // ##########################################################
   for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
      logic hit;

      assign hit = wr_ok && (int'(ch_idx) == g);

      always_ff @(posedge clk or negedge nreset) begin
         if (!nreset) begin
            cfg_code[g]  <= '0;
            en[g]        <= 1'b0;
            cfg_write[g] <= 1'b0;
         end else begin
            cfg_write[g] <= hit && (wr_code != cfg_code[g]); // only on real code change
            if (hit) begin
               cfg_code[g] <= wr_code;
               en[g]       <= pwdata[clkgen_reg_pkg::ctrl_en_bit];
            end
         end
      end
   end

   // error response only ever lands in an access cycle
   a_slverr_in_access: assert property (@(posedge clk) disable iff (!nreset)
      pslverr |-> (psel && penable));

endmodule

`default_nettype wire

// ==== verilog/clkgen_top.sv ====
// programmable clock generator top level
// apb register file and NUM_CH divider channels
`timescale 1ns/10ps
`default_nettype none

module clkgen_top #(
   parameter int NUM_CH = 2
) (
   input  logic                                       clk,
   input  logic                                       nreset,
   input  logic [clkgen_reg_pkg::apb_addr_width-1:0]  paddr,
   input  logic                                       psel,
   input  logic                                       penable,
   input  logic                                       pwrite,
   input  logic [clkgen_reg_pkg::apb_data_width-1:0]  pwdata,
   output logic [clkgen_reg_pkg::apb_data_width-1:0]  prdata,
   output logic                                       pready,
   output logic                                       pslverr,
   output logic [NUM_CH-1:0]                          clkout,
   output logic [NUM_CH-1:0]                          clkout90
);

   logic [clkdiv_pkg::div_code_width-1:0] cfg_code [NUM_CH];
   logic [NUM_CH-1:0]                     en;
   logic [NUM_CH-1:0]                     cfg_write;
   logic [NUM_CH-1:0]                     busy;

   clkgen_regs #(.NUM_CH(NUM_CH)) u_regs (
      .clk, .nreset,
      .paddr, .psel, .penable, .pwrite, .pwdata,
      .prdata, .pready, .pslverr,
      .cfg_code, .en, .cfg_write, .busy
   );

   // ##########################################################
   // divider channels
   // ##########################################################
   for (genvar g = 0; g < NUM_CH; g++) begin : g_chan
      logic [clkdiv_pkg::div_code_width-1:0] active_code;
      logic restart;
      logic period_end;
      logic rise_match, fall_match, rise90_match, fall90_match;

      clkdiv_switch_fsm u_fsm (
         .clk, .nreset,
         .cfg_code(cfg_code[g]), .cfg_write(cfg_write[g]), .en(en[g]),
         .period_end, .active_code, .restart, .busy(busy[g])
      );

      clkdiv_counter u_cnt (
         .clk, .nreset, .active_code, .en(en[g]), .restart,
         .rise_match, .fall_match, .rise90_match, .fall90_match, .period_end
      );

      clkdiv_phase u_phase (
         .clk, .nreset, .active_code,
         .rise_match, .fall_match, .rise90_match, .fall90_match,
         .clkout(clkout[g]), .clkout90(clkout90[g])
      );
   end

endmodule

`default_nettype wire
